// File: exu_pkg.sv
package exu_pkg;

    // datapath width
    localparam int xlen = 64;

    typedef logic [xlen-1:0] xlen_t;

    // iteration counts of the multi-cycle units
    localparam int mul_cycles = 64;
    localparam int div_cycles = 64;

    // counter widths for the iteration counters
    localparam int mul_cnt_w = $clog2(mul_cycles);
    localparam int div_cnt_w = $clog2(div_cycles);

    // alu opcodes, unlisted codes return 0
    typedef enum logic [4:0] {
        alu_add      = 5'd0,
        alu_sub      = 5'd1,
        alu_return_a = 5'd2,
        alu_return_b = 5'd3,
        alu_xor      = 5'd4,
        alu_or       = 5'd5,
        alu_and      = 5'd6,
        alu_sll      = 5'd7,
        alu_srl      = 5'd8,
        alu_slt      = 5'd9,
        alu_sltu     = 5'd10,
        alu_mul      = 5'd11,
        alu_rem      = 5'd12,
        alu_divu     = 5'd13,
        alu_remu     = 5'd14,
        alu_div      = 5'd15,
        alu_sra      = 5'd16,
        alu_eq       = 5'd17,
        alu_loe      = 5'd18,
        alu_loeu     = 5'd19
    } alu_op_t;

    // operand a source, anything but rs1 picks pc
    typedef enum logic [1:0] {
        sel_a_pc  = 2'd0,
        sel_a_rs1 = 2'd1
    } sel_a_t;

    // operand b source, anything but rs2/csr picks imm
    typedef enum logic [1:0] {
        sel_b_imm = 2'd0,
        sel_b_rs2 = 2'd1,
        sel_b_csr = 2'd2
    } sel_b_t;

    // operations handled by the iterative units
    typedef enum logic [2:0] {
        md_mul  = 3'd0,
        md_div  = 3'd1,
        md_divu = 3'd2,
        md_rem  = 3'd3,
        md_remu = 3'd4
    } md_op_t;

    // registered alu result
    typedef struct packed {
        logic  valid;
        xlen_t data;
    } exu_res_t;

endpackage

// File: exu_md_if.sv
`timescale 1ns/1ns

interface exu_md_if import exu_pkg::*; ();

    // request side, driven by the alu
    logic   req;
    md_op_t op;
    xlen_t  a;
    xlen_t  b;
    logic   flush;

    // response side, driven by the iterative unit
    logic   busy;
    logic   done;
    xlen_t  result;

    modport controller (
        output req, op, a, b, flush,
        input  busy, done, result
    );

    modport unit (
        input  req, op, a, b, flush,
        output busy, done, result
    );

endinterface

// File: exu_alu.sv
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    in_valid,
    input  alu_op_t operate,
    input  xlen_t   pc,
    input  xlen_t   rs1,
    input  xlen_t   rs2,
    input  xlen_t   csr,
    input  xlen_t   imm,
    input  sel_a_t  sel_a,
    input  sel_b_t  sel_b,
    input  logic    rs1to32,
    output xlen_t   res,
    output logic    res_valid,
    output logic    alu_wait,
    exu_md_if.controller mul_bus,
    exu_md_if.controller div_bus
);

    typedef enum logic {
        st_idle,
        st_wait
    } alu_state_t;

    alu_state_t state;
    exu_res_t   res_q;
    xlen_t      a;
    xlen_t      b;
    xlen_t      alu_out;
    logic       is_md;
    md_op_t     md_op;
    md_op_t     md_op_q;
    xlen_t      md_a_q;
    xlen_t      md_b_q;
    logic       md_done;
    xlen_t      md_result;

    // operand a with rs1 optionally zero-extended from its low word
    assign a = (sel_a == sel_a_rs1) ? (rs1to32 ? {32'b0, rs1[31:0]} : rs1) : pc;
    assign b = (sel_b == sel_b_rs2) ? rs2 : ((sel_b == sel_b_csr) ? csr : imm);

    // single-cycle operations
    always_comb begin
        case (operate)
            alu_add:      alu_out = a + b;
            alu_sub:      alu_out = a - b;
            alu_return_a: alu_out = a;
            alu_return_b: alu_out = b;
            alu_xor:      alu_out = a ^ b;
            alu_or:       alu_out = a | b;
            alu_and:      alu_out = a & b;
            alu_sll:      alu_out = a << b[5:0];
            alu_srl:      alu_out = a >> b[5:0];
            alu_slt:      alu_out = {63'b0, $signed(a) < $signed(b)};
            alu_sltu:     alu_out = {63'b0, a < b};
            // word mode shifts the signed low word and zero-extends the result
            alu_sra: begin
                if (rs1to32) begin
                    alu_out = {32'b0, $signed(a[31:0]) >>> b[5:0]};
                end else begin
                    alu_out = $signed(a) >>> b[5:0];
                end
            end
            alu_eq:       alu_out = {63'b0, a == b};
            alu_loe:      alu_out = {63'b0, $signed(a) >= $signed(b)};
            alu_loeu:     alu_out = {63'b0, a >= b};
            default:      alu_out = '0;
        endcase
    end

    // opcodes served by the iterative units
    always_comb begin
        is_md = 1'b1;
        md_op = md_mul;
        case (operate)
            alu_mul:  md_op = md_mul;
            alu_div:  md_op = md_div;
            alu_divu: md_op = md_divu;
            alu_rem:  md_op = md_rem;
            alu_remu: md_op = md_remu;
            default:  is_md = 1'b0;
        endcase
    end

    // only one unit runs at a time
    assign md_done   = mul_bus.done | div_bus.done;
    assign md_result = mul_bus.done ? mul_bus.result : div_bus.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            res_q.valid <= 1'b0;
            mul_bus.req <= 1'b0;
            div_bus.req <= 1'b0;
        end else begin
            res_q.valid <= 1'b0;
            mul_bus.req <= 1'b0;
            div_bus.req <= 1'b0;
            if (flush) begin
                // drop whatever is in flight
                state <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        if (in_valid && is_md) begin
                            state       <= st_wait;
                            mul_bus.req <= (md_op == md_mul);
                            div_bus.req <= (md_op != md_mul);
                        end else if (in_valid) begin
                            res_q.valid <= 1'b1;
                            res_q.data  <= alu_out;
                        end
                    end
                    st_wait: begin
                        if (md_done) begin
                            state       <= st_idle;
                            res_q.valid <= 1'b1;
                            res_q.data  <= md_result;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // operands held stable for the unit while req is up
    always_ff @(posedge clk) begin
        if (in_valid && state == st_idle) begin
            md_op_q <= md_op;
            md_a_q  <= a;
            md_b_q  <= b;
        end
    end

    assign mul_bus.op    = md_op_q;
    assign mul_bus.a     = md_a_q;
    assign mul_bus.b     = md_b_q;
    assign mul_bus.flush = flush;
    assign div_bus.op    = md_op_q;
    assign div_bus.a     = md_a_q;
    assign div_bus.b     = md_b_q;
    assign div_bus.flush = flush;

    assign res       = res_q.data;
    assign res_valid = res_q.valid;
    assign alu_wait  = (state == st_wait);

endmodule

// File: exu_mul.sv
`timescale 1ns/1ns

module exu_mul import exu_pkg::*; (
    input logic clk,
    input logic rst_n,
    exu_md_if.unit bus
);

    logic [mul_cnt_w-1:0] cnt;
    xlen_t                mcand_q;
    xlen_t                mplier_q;
    xlen_t                acc_q;
    logic                 start;
    logic                 last;

    // new request only taken while idle
    assign start = bus.req && !bus.busy;
    assign last  = (cnt == mul_cnt_w'(mul_cycles - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
            cnt      <= '0;
        end else if (bus.flush) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else if (start) begin
            bus.busy <= 1'b1;
            bus.done <= 1'b0;
            cnt      <= '0;
        end else if (bus.done) begin
            // busy and done fall together
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else if (bus.busy) begin
            cnt      <= cnt + 1'b1;
            bus.done <= last;
        end
    end

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= bus.a;
            mplier_q <= bus.b;
            acc_q    <= '0;
        end else if (bus.busy && !bus.done) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            // bits shifted past the top are not needed for the low half
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign bus.result = acc_q;

endmodule

// File: exu_div.sv
`timescale 1ns/1ns

module exu_div import exu_pkg::*; (
    input logic clk,
    input logic rst_n,
    exu_md_if.unit bus
);

    logic [div_cnt_w-1:0] cnt;
    logic                 start;
    logic                 last;
    logic                 is_signed;
    logic                 is_rem;
    logic                 a_neg;
    logic                 b_neg;
    xlen_t                a_mag;
    xlen_t                b_mag;
    logic                 by_zero;
    logic                 overflow;
    xlen_t                quo_q;
    xlen_t                rem_q;
    xlen_t                dvs_q;
    logic                 rem_op_q;
    logic                 neg_quo_q;
    logic                 neg_rem_q;
    logic [xlen:0]        shift;
    logic [xlen:0]        diff;
    logic                 fits;
    xlen_t                quo_next;
    xlen_t                rem_next;

    assign start = bus.req && !bus.busy;
    assign last  = (cnt == div_cnt_w'(div_cycles - 1));

    // request decode and operand magnitudes
    always_comb begin
        is_signed = (bus.op == md_div) || (bus.op == md_rem);
        is_rem    = (bus.op == md_rem) || (bus.op == md_remu);
        a_neg     = is_signed && bus.a[xlen-1];
        b_neg     = is_signed && bus.b[xlen-1];
        a_mag     = a_neg ? -bus.a : bus.a;
        b_mag     = b_neg ? -bus.b : bus.b;
        by_zero   = (bus.b == '0);
        // most negative over minus one
        overflow  = is_signed && (bus.a == {1'b1, {(xlen-1){1'b0}}}) && (bus.b == '1);
    end

    // one restoring step
    always_comb begin
        shift    = {rem_q, quo_q[xlen-1]};
        diff     = shift - {1'b0, dvs_q};
        fits     = !diff[xlen];
        rem_next = fits ? diff[xlen-1:0] : shift[xlen-1:0];
        quo_next = {quo_q[xlen-2:0], fits};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
            cnt      <= '0;
        end else if (bus.flush) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else if (start) begin
            bus.busy <= 1'b1;
            // special cases finish right away
            bus.done <= by_zero || overflow;
            cnt      <= '0;
        end else if (bus.done) begin
            bus.busy <= 1'b0;
            bus.done <= 1'b0;
        end else if (bus.busy) begin
            cnt      <= cnt + 1'b1;
            bus.done <= last;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo_q     <= a_mag;
            rem_q     <= '0;
            dvs_q     <= b_mag;
            rem_op_q  <= is_rem;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            if (by_zero) begin
                bus.result <= is_rem ? bus.a : '1;
            end else if (overflow) begin
                bus.result <= is_rem ? '0 : bus.a;
            end
        end else if (bus.busy && !bus.done) begin
            quo_q <= quo_next;
            rem_q <= rem_next;
            // sign fix on the final step
            if (last) begin
                if (rem_op_q) begin
                    bus.result <= neg_rem_q ? -rem_next : rem_next;
                end else begin
                    bus.result <= neg_quo_q ? -quo_next : quo_next;
                end
            end
        end
    end

endmodule

// File: exu_top.sv
`timescale 1ns/1ns

module exu_top import exu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  logic    in_valid,
    input  alu_op_t operate,
    input  xlen_t   pc,
    input  xlen_t   rs1,
    input  xlen_t   rs2,
    input  xlen_t   csr,
    input  xlen_t   imm,
    input  sel_a_t  sel_a,
    input  sel_b_t  sel_b,
    input  logic    rs1to32,
    output xlen_t   res,
    output logic    res_valid,
    output logic    alu_wait
);

    // one link per iterative unit
    exu_md_if mul_bus ();
    exu_md_if div_bus ();

    exu_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .operate   (operate),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .res       (res),
        .res_valid (res_valid),
        .alu_wait  (alu_wait),
        .mul_bus   (mul_bus.controller),
        .div_bus   (div_bus.controller)
    );

    exu_mul u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (mul_bus.unit)
    );

    exu_div u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (div_bus.unit)
    );

endmodule

// File: exu_props.sv
`timescale 1ns/1ns

module exu_props (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input logic in_valid,
    input logic res_valid,
    input logic alu_wait,
    input logic mul_req,
    input logic mul_busy,
    input logic mul_done,
    input logic div_req,
    input logic div_busy,
    input logic div_done
);

    int fail_cnt = 0;

    // a request only goes to an idle unit
    req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_req && mul_busy) && !(div_req && div_busy))
        else begin
            $error("req raised while the unit is busy");
            fail_cnt++;
        end

    // done only from a running unit
    done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (!mul_done || mul_busy) && (!div_done || div_busy))
        else begin
            $error("done raised while the unit is not busy");
            fail_cnt++;
        end

    // no result and no new issue while stalled
    stall_rules: assert property (@(posedge clk) disable iff (!rst_n)
        !(res_valid && alu_wait) && !(in_valid && alu_wait))
        else begin
            $error("res_valid or in_valid high during alu_wait");
            fail_cnt++;
        end

    // flush returns the alu and both units to idle without a done
    flush_drop: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !alu_wait && !mul_busy && !div_busy && !mul_done && !div_done)
        else begin
            $error("alu_wait or a unit still active one cycle after flush");
            fail_cnt++;
        end

endmodule

bind exu_alu exu_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .res_valid (res_valid),
    .alu_wait  (alu_wait),
    .mul_req   (mul_bus.req),
    .mul_busy  (mul_bus.busy),
    .mul_done  (mul_bus.done),
    .div_req   (div_bus.req),
    .div_busy  (div_bus.busy),
    .div_done  (div_bus.done)
);

// File: tb_exu.sv
`timescale 1ns/1ns

module tb_exu import exu_pkg::*; ();

    localparam int n_rand = 200;
    localparam int n_mul  = 30;
    localparam int n_div  = 40;
    localparam int n_ops  = n_rand + n_mul + n_div + 40;
    localparam longint watchdog_ns = longint'(n_ops) * (div_cycles + 4) * 8 + 5000;

    logic    clk;
    logic    rst_n;
    logic    flush;
    logic    in_valid;
    alu_op_t operate;
    xlen_t   pc;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   csr;
    xlen_t   imm;
    sel_a_t  sel_a;
    sel_b_t  sel_b;
    logic    rs1to32;
    xlen_t   res;
    logic    res_valid;
    logic    alu_wait;

    // expected results in issue order
    xlen_t   exp_q[$];
    alu_op_t op_q[$];
    int      checks;
    int      errors;
    int      test_checks;
    int      test_errs;

    exu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic xlen_t exu_model(alu_op_t op, xlen_t pc_v, xlen_t rs1_v, xlen_t rs2_v,
            xlen_t csr_v, xlen_t imm_v, sel_a_t sa, sel_b_t sb, logic w);
        xlen_t              x;
        xlen_t              y;
        logic signed [63:0] sx;
        logic signed [63:0] sy;
        logic signed [31:0] lo;
        logic [31:0]        lo_sh;
        if (sa == sel_a_rs1)
            x = w ? xlen_t'(rs1_v[31:0]) : rs1_v;
        else
            x = pc_v;
        case (sb)
            sel_b_rs2: y = rs2_v;
            sel_b_csr: y = csr_v;
            default:   y = imm_v;
        endcase
        sx = x;
        sy = y;
        lo = x[31:0];
        lo_sh = lo >>> y[5:0];
        case (op)
            alu_add:      return x + y;
            alu_sub:      return x - y;
            alu_return_a: return x;
            alu_return_b: return y;
            alu_xor:      return x ^ y;
            alu_or:       return x | y;
            alu_and:      return x & y;
            alu_sll:      return x << y[5:0];
            alu_srl:      return x >> y[5:0];
            alu_sra:      return w ? {32'b0, lo_sh} : xlen_t'(sx >>> y[5:0]);
            alu_slt:      return xlen_t'(sx < sy);
            alu_sltu:     return xlen_t'(x < y);
            alu_eq:       return xlen_t'(x == y);
            alu_loe:      return xlen_t'(sx >= sy);
            alu_loeu:     return xlen_t'(x >= y);
            alu_mul:      return x * y;
            alu_div, alu_divu, alu_rem, alu_remu: begin
                // riscv rules for zero divisor and signed overflow
                if (y == '0)
                    return (op == alu_div || op == alu_divu) ? '1 : x;
                if ((op == alu_div || op == alu_rem) && x == {1'b1, 63'b0} && y == '1)
                    return (op == alu_div) ? x : '0;
                case (op)
                    alu_div:  return sx / sy;
                    alu_rem:  return sx % sy;
                    alu_divu: return x / y;
                    default:  return x % y;
                endcase
            end
            default:      return '0;
        endcase
    endfunction

    function automatic xlen_t rnd64();
        return {$urandom, $urandom};
    endfunction

    task automatic check_res(input xlen_t got, input xlen_t exp, input string what);
        test_checks++;
        if (got !== exp) begin
            test_errs++;
            $display("** Error at %0t ns: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        test_checks++;
        if (got !== exp) begin
            test_errs++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // runs from one falling edge to the next
    task automatic issue(input alu_op_t op, input xlen_t pc_v, rs1_v, rs2_v, csr_v, imm_v,
            input sel_a_t sa, input sel_b_t sb, input logic w, input bit want);
        while (alu_wait)
            @(negedge clk);
        operate  = op;
        pc       = pc_v;
        rs1      = rs1_v;
        rs2      = rs2_v;
        csr      = csr_v;
        imm      = imm_v;
        sel_a    = sa;
        sel_b    = sb;
        rs1to32  = w;
        in_valid = 1'b1;
        if (want) begin
            exp_q.push_back(exu_model(op, pc_v, rs1_v, rs2_v, csr_v, imm_v, sa, sb, w));
            op_q.push_back(op);
        end
        @(negedge clk);
        if (alu_wait)
            in_valid = 1'b0;
    endtask

    task automatic issue_rr(input alu_op_t op, input xlen_t x, y, input logic w, input bit want);
        issue(op, rnd64(), x, y, rnd64(), rnd64(), sel_a_rs1, sel_b_rs2, w, want);
    endtask

    task automatic issue_ri(input alu_op_t op, input xlen_t x, imm_v, input logic w);
        issue(op, rnd64(), x, rnd64(), rnd64(), imm_v, sel_a_rs1, sel_b_imm, w, 1'b1);
    endtask

    task automatic drain();
        int n;
        n = 0;
        in_valid = 1'b0;
        while ((exp_q.size() != 0 || alu_wait) && n < div_cycles + 16) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("no result arrived for %0d pending operation(s) by %0t ns",
                     exp_q.size(), $time);
            test_errs += exp_q.size();
            exp_q.delete();
            op_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        drain();
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
        checks      += test_checks;
        errors      += test_errs;
        test_checks = 0;
        test_errs   = 0;
    endtask

    // results checked on the falling edge where outputs are stable
    initial begin : compare
        xlen_t   e;
        alu_op_t o;
        forever begin
            @(negedge clk);
            if (rst_n && res_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result at %0t ns with no operation pending", $time);
                    test_errs++;
                end else begin
                    e = exp_q.pop_front();
                    o = op_q.pop_front();
                    check_res(res, e, $sformatf("%s (code %0d)", o.name(), o));
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t ns, the run did not finish", $time);
        $display("Errors found");
        $finish;
    end

    initial begin : stimulus
        alu_op_t op;
        alu_op_t div_ops[4];
        alu_op_t cmp_ops[5];
        int      shamt[2];
        int      n;
        void'($urandom(32'h943b_59d4));
        div_ops     = '{alu_div, alu_divu, alu_rem, alu_remu};
        cmp_ops     = '{alu_slt, alu_sltu, alu_loe, alu_loeu, alu_eq};
        shamt       = '{0, 63};
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errs   = 0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        operate  = alu_add;
        pc       = '0;
        rs1      = '0;
        rs2      = '0;
        csr      = '0;
        imm      = '0;
        sel_a    = sel_a_pc;
        sel_b    = sel_b_imm;
        rs1to32  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_bit(res_valid, 1'b0, "res_valid after reset");
        check_bit(alu_wait, 1'b0, "alu_wait after reset");
        end_test("reset state");

        // back to back ops with random selects and word mode
        for (int i = 0; i < n_rand; i++) begin
            do
                op = alu_op_t'(5'($urandom_range(31)));
            while (op inside {alu_mul, alu_div, alu_divu, alu_rem, alu_remu});
            issue(op, rnd64(), rnd64(), rnd64(), rnd64(), rnd64(),
                  sel_a_t'(2'($urandom_range(3))), sel_b_t'(2'($urandom_range(3))),
                  1'($urandom_range(1)), 1'b1);
        end
        end_test("single-cycle random");

        foreach (shamt[j]) begin
            issue_ri(alu_sll, 64'h8000_0000_0000_0001, xlen_t'(shamt[j]), 1'b0);
            issue_ri(alu_srl, 64'h8000_0000_0000_0001, xlen_t'(shamt[j]), 1'b0);
            issue_ri(alu_sra, 64'h8000_0000_0000_0001, xlen_t'(shamt[j]), 1'b0);
        end
        // word sra of a negative low word by the low 6 imm bits
        issue_ri(alu_sra, 64'h1234_5678_8000_00f0, 64'd4, 1'b1);
        issue_ri(alu_sra, 64'h1234_5678_8000_00f0, 64'd63, 1'b1);
        issue_ri(alu_sra, 64'h1234_5678_8000_00f0, 64'hffff_ffff_ffff_ffc4, 1'b1);
        foreach (cmp_ops[j]) begin
            issue_rr(cmp_ops[j], '1, 64'd1, 1'b0, 1'b1);
            issue_rr(cmp_ops[j], 64'd5, 64'd5, 1'b0, 1'b1);
        end
        end_test("shift and compare edges");

        for (int i = 0; i < n_mul; i++) begin
            issue_rr(alu_mul, rnd64(), rnd64(), 1'($urandom_range(1)), 1'b1);
            n = 0;
            while (!res_valid && n < mul_cycles + 16) begin
                check_bit(alu_wait, 1'b1, "alu_wait while mul runs");
                @(negedge clk);
                n++;
            end
        end
        end_test("multiply");

        for (int i = 0; i < n_div; i++) begin
            issue_rr(div_ops[$urandom_range(3)], rnd64(),
                     ($urandom_range(3) == 0) ? xlen_t'(longint'($urandom_range(40)) - 20)
                                              : rnd64(),
                     1'b0, 1'b1);
        end
        foreach (div_ops[j]) begin
            issue_rr(div_ops[j], rnd64(), '0, 1'b0, 1'b1);
            issue_rr(div_ops[j], {1'b1, 63'b0}, '1, 1'b0, 1'b1);
        end
        end_test("divide and remainder");

        // flush a div, then a mul, then run both cleanly
        for (int k = 0; k < 2; k++) begin
            issue_rr((k == 0) ? alu_div : alu_mul, rnd64(), 64'd7, 1'b0, 1'b0);
            repeat ($urandom_range(20, 3)) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            check_bit(alu_wait, 1'b0, "alu_wait after flush");
            repeat (div_cycles + 8) @(negedge clk);
        end
        issue_rr(alu_div, rnd64(), rnd64(), 1'b0, 1'b1);
        issue_rr(alu_mul, rnd64(), rnd64(), 1'b0, 1'b1);
        end_test("flush");

        errors += UUT.u_alu.u_props.fail_cnt;
        $display("summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_alu.u_props.fail_cnt);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: exu_top.f
exu_pkg.sv
exu_md_if.sv
exu_alu.sv
exu_mul.sv
exu_div.sv
exu_top.sv
exu_props.sv
tb_exu.sv
